/* design/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and program counter width.
`define XLEN 32

// RV32E keeps sixteen integer registers behind a five-bit index.
`define GPR_COUNT 16
`define GPR_INDEX_BITS 5

`define CSR_ADDR_BITS 12

// machine CSR constants.
`define MSTATUS_RESET 32'h0000_1800
`define MVENDORID_VALUE 32'h7973_7978
`define MARCHID_VALUE 32'h017D_9F58

`endif

/* design/rv_csr_pkg.sv */
`include "core_params.svh"

package rv_csr_pkg;

  // Machine-mode CSR addresses implemented by the commit block.
  typedef enum logic [`CSR_ADDR_BITS-1:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MTVEC     = 12'h305,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MVENDORID = 12'hF11,
    CSR_MARCHID   = 12'hF12
  } csr_addr_e;

  // synchronous exception causes as written to mcause.
  typedef enum logic [`XLEN-1:0] {
    CAUSE_INST_MISALIGNED  = 32'd0,
    CAUSE_LOAD_MISALIGNED  = 32'd4,
    CAUSE_STORE_MISALIGNED = 32'd6,
    CAUSE_ECALL_M          = 32'd11
  } exc_cause_e;

endpackage

/* design/commit_pkg.sv */
package commit_pkg;

  // what a retiring instruction does to the fetch stream.
  typedef enum logic [2:0] {
    REDIR_NONE       = 3'd0,
    REDIR_TRAP       = 3'd1,
    REDIR_MRET       = 3'd2,
    REDIR_FENCE_I    = 3'd3,
    REDIR_MISPREDICT = 3'd4
  } redirect_kind_e;

  // any redirect other than a plain retire restarts the pipeline.
  function automatic logic redirect_flushes(input redirect_kind_e kind);
    return kind != REDIR_NONE;
  endfunction

endpackage

/* design/csr_if.sv */
`timescale 1ns/1ps
`include "core_params.svh"

interface csr_if import rv_csr_pkg::*; ();

  logic             trap_take;  // one-cycle trap capture request.
  exc_cause_e       trap_cause;
  logic [`XLEN-1:0] trap_pc;    // pc of the faulting instruction.
  logic             csr_we;     // already qualified by the trap unit.

  // live CSR values needed for redirects.
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;

  modport ctrl (
    output trap_take,
    output trap_cause,
    output trap_pc,
    output csr_we,
    input  mtvec,
    input  mepc
  );

  modport regs (
    input  trap_take,
    input  trap_cause,
    input  trap_pc,
    input  csr_we,
    output mtvec,
    output mepc
  );

endinterface

/* design/gpr_file.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module gpr_file (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [`GPR_INDEX_BITS-1:0] rs1,
  input  logic [`GPR_INDEX_BITS-1:0] rs2,
  input  logic [`GPR_INDEX_BITS-1:0] rd,
  input  logic                       we,
  input  logic [`XLEN-1:0]           wdata,
  output logic [`XLEN-1:0]           src1,
  output logic [`XLEN-1:0]           src2
);

  logic [`XLEN-1:0] regs [`GPR_COUNT];

  // RV32E ignores the top index bit.
  logic [$clog2(`GPR_COUNT)-1:0] rs1_sel;
  logic [$clog2(`GPR_COUNT)-1:0] rs2_sel;
  logic [$clog2(`GPR_COUNT)-1:0] rd_sel;

  assign rs1_sel = rs1[$clog2(`GPR_COUNT)-1:0];
  assign rs2_sel = rs2[$clog2(`GPR_COUNT)-1:0];
  assign rd_sel  = rd[$clog2(`GPR_COUNT)-1:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `GPR_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_sel != '0) begin  // x0 stays hardwired to zero.
      regs[rd_sel] <= wdata;
    end
  end

  assign src1 = regs[rs1_sel];
  assign src2 = regs[rs2_sel];

endmodule

/* design/csr_file.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module csr_file import rv_csr_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  csr_if.regs                       csr,
  input  logic [`CSR_ADDR_BITS-1:0] csr_s,
  input  logic [`CSR_ADDR_BITS-1:0] csr_d,
  input  logic [`XLEN-1:0]          csr_wdata,
  output logic [`XLEN-1:0]          csr_src
);

  logic [`XLEN-1:0] mstatus;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;
  logic [`XLEN-1:0] mcause;

  // a trap wins over a software write, although the two never meet.
  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= `MSTATUS_RESET;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (csr.trap_take) begin
      mcause <= csr.trap_cause;
      mepc   <= csr.trap_pc;
    end else if (csr.csr_we) begin
      case (csr_d)
        CSR_MSTATUS: mstatus <= csr_wdata;
        CSR_MTVEC:   mtvec   <= csr_wdata;
        CSR_MEPC:    mepc    <= csr_wdata;
        default: begin
        end  // mcause and the ID registers are not writable here.
      endcase
    end
  end

  always_comb begin
    case (csr_s)
      CSR_MSTATUS:   csr_src = mstatus;
      CSR_MTVEC:     csr_src = mtvec;
      CSR_MEPC:      csr_src = mepc;
      CSR_MCAUSE:    csr_src = mcause;
      CSR_MVENDORID: csr_src = `MVENDORID_VALUE;
      CSR_MARCHID:   csr_src = `MARCHID_VALUE;
      default:       csr_src = '0;  // unimplemented addresses read as zero.
    endcase
  end

  assign csr.mtvec = mtvec;
  assign csr.mepc  = mepc;

  // the trap unit must never combine a trap with a committed CSR write.
  a_trap_excludes_write : assert property (
    @(posedge clock) disable iff (reset)
    !(csr.trap_take && csr.csr_we)
  );

endmodule

/* design/trap_unit.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module trap_unit import rv_csr_pkg::*, commit_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             commit_valid,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] commit_npc,
  input  logic             wen,
  input  logic             csr_wen,
  input  logic             inst_addr_misaligned,
  input  logic             ecall,
  input  logic             load_addr_misaligned,
  input  logic             store_addr_misaligned,
  input  logic             mret,
  input  logic             fence_i,
  input  logic             wrong_prediction,
  output logic             gpr_we,
  csr_if.ctrl              csr,
  output logic             clear_pipeline,
  output logic             clear_cache,
  output logic             npc_valid,
  output logic [`XLEN-1:0] npc
);

  logic             accept;
  logic             exception;
  exc_cause_e       cause;
  redirect_kind_e   kind;
  logic [`XLEN-1:0] npc_d;

  // instructions behind a flush are already stale.
  assign accept = commit_valid && !clear_pipeline;

  assign exception = inst_addr_misaligned || ecall ||
                     load_addr_misaligned || store_addr_misaligned;

  always_comb begin
    if (inst_addr_misaligned) begin
      cause = CAUSE_INST_MISALIGNED;
    end else if (ecall) begin
      cause = CAUSE_ECALL_M;
    end else if (load_addr_misaligned) begin
      cause = CAUSE_LOAD_MISALIGNED;
    end else begin
      cause = CAUSE_STORE_MISALIGNED;
    end
  end

  always_comb begin
    if (exception) begin
      kind = REDIR_TRAP;
    end else if (mret) begin
      kind = REDIR_MRET;
    end else if (fence_i) begin
      kind = REDIR_FENCE_I;
    end else if (wrong_prediction) begin
      kind = REDIR_MISPREDICT;
    end else begin
      kind = REDIR_NONE;
    end
  end

  // mepc is sampled before this commit's edge, which is the return target.
  always_comb begin
    case (kind)
      REDIR_TRAP: npc_d = csr.mtvec;
      REDIR_MRET: npc_d = csr.mepc;
      default:    npc_d = commit_npc;
    endcase
  end

  // a trapping instruction must leave no architectural side effect.
  assign gpr_we         = accept && wen && !exception;
  assign csr.csr_we     = accept && csr_wen && !exception;
  assign csr.trap_take  = accept && exception;
  assign csr.trap_cause = cause;
  assign csr.trap_pc    = pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      npc_valid      <= 1'b0;
      clear_pipeline <= 1'b0;
      clear_cache    <= 1'b0;
      npc            <= '0;
    end else begin
      npc_valid      <= accept;
      clear_pipeline <= accept && redirect_flushes(kind);
      clear_cache    <= accept && fence_i && !exception;
      if (accept) begin
        npc <= npc_d;  // holds between commits.
      end
    end
  end

  a_cache_needs_flush : assert property (
    @(posedge clock) disable iff (reset)
    clear_cache |-> clear_pipeline
  );

  a_flush_is_pulse : assert property (
    @(posedge clock) disable iff (reset)
    clear_pipeline |=> !clear_pipeline
  );

  // a commit squashed by the flush must not retire.
  a_squash_no_retire : assert property (
    @(posedge clock) disable iff (reset)
    (clear_pipeline && commit_valid) |=> !npc_valid
  );

endmodule

/* design/commit_top.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module commit_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       commit_valid,
  input  logic [`XLEN-1:0]           pc,
  input  logic [`XLEN-1:0]           commit_npc,
  input  logic                       wen,
  input  logic [`GPR_INDEX_BITS-1:0] rd,
  input  logic [`XLEN-1:0]           wdata,
  input  logic                       csr_wen,
  input  logic [`CSR_ADDR_BITS-1:0]  csr_d,
  input  logic [`XLEN-1:0]           csr_wdata,
  input  logic                       inst_addr_misaligned,
  input  logic                       ecall,
  input  logic                       load_addr_misaligned,
  input  logic                       store_addr_misaligned,
  input  logic                       mret,
  input  logic                       fence_i,
  input  logic                       wrong_prediction,
  input  logic [`GPR_INDEX_BITS-1:0] rs1,
  input  logic [`GPR_INDEX_BITS-1:0] rs2,
  input  logic [`CSR_ADDR_BITS-1:0]  csr_s,
  output logic [`XLEN-1:0]           src1,
  output logic [`XLEN-1:0]           src2,
  output logic [`XLEN-1:0]           csr_src,
  output logic [`XLEN-1:0]           npc,
  output logic                       npc_valid,
  output logic                       clear_pipeline,
  output logic                       clear_cache
);

  logic gpr_we;

  csr_if csr_link ();

  trap_unit u_trap_unit (
    .clock                 (clock),
    .reset                 (reset),
    .commit_valid          (commit_valid),
    .pc                    (pc),
    .commit_npc            (commit_npc),
    .wen                   (wen),
    .csr_wen               (csr_wen),
    .inst_addr_misaligned  (inst_addr_misaligned),
    .ecall                 (ecall),
    .load_addr_misaligned  (load_addr_misaligned),
    .store_addr_misaligned (store_addr_misaligned),
    .mret                  (mret),
    .fence_i               (fence_i),
    .wrong_prediction      (wrong_prediction),
    .gpr_we                (gpr_we),
    .csr                   (csr_link.ctrl),
    .clear_pipeline        (clear_pipeline),
    .clear_cache           (clear_cache),
    .npc_valid             (npc_valid),
    .npc                   (npc)
  );

  gpr_file u_gpr_file (
    .clock (clock),
    .reset (reset),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .we    (gpr_we),
    .wdata (wdata),
    .src1  (src1),
    .src2  (src2)
  );

  csr_file u_csr_file (
    .clock     (clock),
    .reset     (reset),
    .csr       (csr_link.regs),
    .csr_s     (csr_s),
    .csr_d     (csr_d),
    .csr_wdata (csr_wdata),
    .csr_src   (csr_src)
  );

endmodule

/* tests/commit_tb.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module commit_tb import rv_csr_pkg::*, commit_pkg::*; ();

  localparam int RETIRE_TIMEOUT = 8;

  localparam logic [6:0] F_NONE  = 7'h00;
  localparam logic [6:0] F_INST  = 7'h01;
  localparam logic [6:0] F_ECALL = 7'h02;
  localparam logic [6:0] F_LOAD  = 7'h04;
  localparam logic [6:0] F_STORE = 7'h08;
  localparam logic [6:0] F_MRET  = 7'h10;
  localparam logic [6:0] F_FENCE = 7'h20;
  localparam logic [6:0] F_MISP  = 7'h40;

  localparam logic [1:0] W_NONE = 2'b00;  // {wen, csr_wen}.
  localparam logic [1:0] W_CSR  = 2'b01;
  localparam logic [1:0] W_GPR  = 2'b10;
  localparam logic [1:0] W_BOTH = 2'b11;

  localparam logic [1:0] P_NONE  = 2'b00;  // {clear_pipeline, clear_cache}.
  localparam logic [1:0] P_FLUSH = 2'b10;
  localparam logic [1:0] P_BOTH  = 2'b11;

  typedef struct {
    string          name;
    redirect_kind_e kind;
    logic [6:0]     flags;
    logic [31:0]    pc;
    logic [31:0]    cnpc;
    logic [1:0]     we;
    logic [4:0]     rd;
    logic [31:0]    wdata;
    logic [11:0]    csr_d;
    logic [31:0]    csr_wdata;
    logic [11:0]    csr_s;
    logic [1:0]     pulses;
    bit             squash;  // presented while the previous row's flush is high.
  } row_t;

  logic clock, reset, commit_valid, wen, csr_wen;
  logic inst_addr_misaligned, ecall, load_addr_misaligned, store_addr_misaligned;
  logic mret, fence_i, wrong_prediction;
  logic [31:0] pc, commit_npc, wdata, csr_wdata;
  logic [4:0] rd, rs1, rs2;
  logic [11:0] csr_d, csr_s;
  logic [31:0] src1, src2, csr_src, npc;
  logic npc_valid, clear_pipeline, clear_cache;

  logic [31:0] gpr_model [16];
  logic [31:0] mstatus_m, mtvec_m, mepc_m, mcause_m;
  row_t rows[$];
  int checks = 0;
  int errors = 0;
  int idx;

  commit_top DUT (.*);

  always #50 clock = ~clock;

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [31:0] csr_expect(input logic [11:0] addr);
    case (addr)
      12'h300: return mstatus_m;
      12'h305: return mtvec_m;
      12'h341: return mepc_m;
      12'h342: return mcause_m;
      12'hF11: return `MVENDORID_VALUE;
      12'hF12: return `MARCHID_VALUE;
      default: return 32'h0;
    endcase
  endfunction

  // lowest flag wins: inst misaligned, ecall, load misaligned, store misaligned.
  function automatic logic [31:0] cause_expect(input logic [6:0] flags);
    if (flags[0]) return 32'd0;
    if (flags[1]) return 32'd11;
    if (flags[2]) return 32'd4;
    return 32'd6;
  endfunction

  task automatic push_row(input string name, input redirect_kind_e kind, input logic [6:0] flags,
                          input logic [1:0] we, input logic [4:0] rd_idx,
                          input logic [11:0] dst, input logic [11:0] src,
                          input logic [1:0] pulses, input bit squash);
    row_t r;
    r.name      = name;
    r.kind      = kind;
    r.flags     = flags;
    r.pc        = 32'h1000 + 32'(rows.size()) * 32'd4;
    r.cnpc      = r.pc + (flags[6] ? 32'h200 : 32'h4);
    r.we        = we;
    r.rd        = rd_idx;
    r.wdata     = $urandom();
    r.csr_d     = dst;
    r.csr_wdata = $urandom();
    r.csr_s     = src;
    r.pulses    = pulses;
    r.squash    = squash;
    rows.push_back(r);
  endtask

  task automatic drive_commit(input row_t r);
    commit_valid = 1'b1;
    pc           = r.pc;
    commit_npc   = r.cnpc;
    wen          = r.we[1];
    rd           = r.rd;
    wdata        = r.wdata;
    csr_wen      = r.we[0];
    csr_d        = r.csr_d;
    csr_wdata    = r.csr_wdata;
    {wrong_prediction, fence_i, mret, store_addr_misaligned,
     load_addr_misaligned, ecall, inst_addr_misaligned} = r.flags;
    rs1   = r.rd;
    rs2   = {~r.rd[4], r.rd[3:0]};  // same register through the other index alias.
    csr_s = r.csr_s;
  endtask

  task automatic model_commit(input row_t r, output logic [31:0] exp_npc);
    logic exc;
    exc = |r.flags[3:0];
    if (exc) begin
      exp_npc  = mtvec_m;
      mcause_m = cause_expect(r.flags);
      mepc_m   = r.pc;
    end else begin
      exp_npc = r.flags[4] ? mepc_m : r.cnpc;  // mret returns to the old mepc.
      if (r.we[1] && r.rd[3:0] != 4'd0) gpr_model[r.rd[3:0]] = r.wdata;
      if (r.we[0]) begin
        case (r.csr_d)
          12'h300: mstatus_m = r.csr_wdata;
          12'h305: mtvec_m   = r.csr_wdata;
          12'h341: mepc_m    = r.csr_wdata;
          default: ;
        endcase
      end
    end
  endtask

  task automatic check_reads(input string name);
    check({name, " src1"}, gpr_model[rs1[3:0]], src1);
    check({name, " src2"}, gpr_model[rs2[3:0]], src2);
    check({name, " csr_src"}, csr_expect(csr_s), csr_src);
  endtask

  task automatic check_state(input string tag);
    logic [11:0] csr_list [7];
    csr_list = '{12'h300, 12'h305, 12'h341, 12'h342, 12'hF11, 12'hF12, 12'h7C0};
    for (int i = 0; i < 16; i++) begin
      rs1   = 5'(i);
      rs2   = 5'(i + 16);
      csr_s = csr_list[i % 7];
      #20;
      check_reads($sformatf("%s sweep %0d", tag, i));
      @(negedge clock);
    end
  endtask

  task automatic apply_row(input row_t r, input bit squash_next, input row_t s);
    logic [31:0] exp_npc;
    int cycles;
    string label;
    label = $sformatf("%s/%s", r.name, r.kind.name());
    drive_commit(r);
    model_commit(r, exp_npc);
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!npc_valid && cycles < RETIRE_TIMEOUT);
    if (!npc_valid) begin
      errors++;
      $display("timeout: %s did not retire within %0d cycles", label, RETIRE_TIMEOUT);
    end
    check({label, " latency"}, 32'd1, 32'(cycles));
    check({label, " npc"}, exp_npc, npc);
    check({label, " clear_pipeline"}, 32'(r.pulses[1]), 32'(clear_pipeline));
    check({label, " clear_cache"}, 32'(r.pulses[0]), 32'(clear_cache));
    check_reads(label);
    if (squash_next) begin
      drive_commit(s);  // the model is left alone, this commit must vanish.
      @(negedge clock);
      check({s.name, " retire"}, 32'd0, {29'd0, npc_valid, clear_pipeline, clear_cache});
      check({s.name, " npc"}, exp_npc, npc);
      check_reads(s.name);
    end
    commit_valid = 1'b0;
    @(negedge clock);
    check({label, " pulse end"}, 32'd0, {29'd0, npc_valid, clear_pipeline, clear_cache});
  endtask

  initial begin
    void'($urandom(32'h3a02));
    clock        = 1'b0;
    reset        = 1'b1;
    commit_valid = 1'b0;
    pc           = '0;
    commit_npc   = '0;
    wen          = 1'b0;
    rd           = '0;
    wdata        = '0;
    csr_wen      = 1'b0;
    csr_d        = '0;
    csr_wdata    = '0;
    {wrong_prediction, fence_i, mret, store_addr_misaligned,
     load_addr_misaligned, ecall, inst_addr_misaligned} = 7'h00;
    rs1   = '0;
    rs2   = '0;
    csr_s = '0;
    for (int i = 0; i < 16; i++) gpr_model[i] = '0;
    mstatus_m = `MSTATUS_RESET;
    mtvec_m   = '0;
    mepc_m    = '0;
    mcause_m  = '0;

    for (int i = 0; i < 32; i++) begin
      push_row($sformatf("gpr_write_%0d", i), REDIR_NONE, F_NONE, W_GPR, 5'(i),
               CSR_MSTATUS, CSR_MVENDORID, P_NONE, 1'b0);
    end
    push_row("csr_mtvec", REDIR_NONE, F_NONE, W_CSR, 5'd1, CSR_MTVEC, CSR_MTVEC, P_NONE, 1'b0);
    push_row("csr_mepc", REDIR_NONE, F_NONE, W_CSR, 5'd2, CSR_MEPC, CSR_MEPC, P_NONE, 1'b0);
    push_row("csr_mstatus", REDIR_NONE, F_NONE, W_CSR, 5'd3, CSR_MSTATUS, CSR_MSTATUS, P_NONE, 1'b0);
    push_row("csr_marchid", REDIR_NONE, F_NONE, W_CSR, 5'd4, CSR_MARCHID, CSR_MARCHID, P_NONE, 1'b0);
    push_row("csr_unknown", REDIR_NONE, F_NONE, W_CSR, 5'd4, 12'h7C0, 12'h7C0, P_NONE, 1'b0);
    push_row("csr_mcause", REDIR_NONE, F_NONE, W_CSR, 5'd4, CSR_MCAUSE, CSR_MCAUSE, P_NONE, 1'b0);
    push_row("trap_inst", REDIR_TRAP, F_INST, W_BOTH, 5'd5, CSR_MTVEC, CSR_MCAUSE, P_FLUSH, 1'b0);
    push_row("trap_ecall", REDIR_TRAP, F_ECALL, W_BOTH, 5'd6, CSR_MEPC, CSR_MCAUSE, P_FLUSH, 1'b0);
    push_row("trap_load", REDIR_TRAP, F_LOAD, W_GPR, 5'd7, CSR_MTVEC, CSR_MEPC, P_FLUSH, 1'b0);
    push_row("trap_store", REDIR_TRAP, F_STORE, W_BOTH, 5'd8, CSR_MSTATUS, CSR_MCAUSE,
             P_FLUSH, 1'b0);
    push_row("prio_all", REDIR_TRAP, F_INST | F_ECALL | F_LOAD | F_STORE, W_GPR, 5'd9,
             CSR_MTVEC, CSR_MCAUSE, P_FLUSH, 1'b0);
    push_row("prio_ecall", REDIR_TRAP, F_ECALL | F_LOAD | F_STORE, W_GPR, 5'd9,
             CSR_MTVEC, CSR_MCAUSE, P_FLUSH, 1'b0);
    push_row("prio_load", REDIR_TRAP, F_LOAD | F_STORE, W_GPR, 5'd9, CSR_MTVEC, CSR_MCAUSE,
             P_FLUSH, 1'b0);
    push_row("prio_mret", REDIR_TRAP, F_STORE | F_MRET, W_GPR, 5'd9, CSR_MTVEC, CSR_MEPC,
             P_FLUSH, 1'b0);
    push_row("prio_fence", REDIR_TRAP, F_LOAD | F_FENCE, W_GPR, 5'd9, CSR_MTVEC, CSR_MCAUSE,
             P_FLUSH, 1'b0);
    push_row("squash_trap", REDIR_NONE, F_NONE, W_BOTH, 5'd10, CSR_MTVEC, CSR_MTVEC, P_NONE, 1'b1);
    push_row("mret", REDIR_MRET, F_MRET, W_GPR, 5'd11, CSR_MEPC, CSR_MEPC, P_FLUSH, 1'b0);
    push_row("csr_mepc_2", REDIR_NONE, F_NONE, W_CSR, 5'd11, CSR_MEPC, CSR_MEPC, P_NONE, 1'b0);
    push_row("mret_2", REDIR_MRET, F_MRET, W_NONE, 5'd11, CSR_MEPC, CSR_MEPC, P_FLUSH, 1'b0);
    push_row("squash_mret", REDIR_NONE, F_NONE, W_GPR, 5'd12, CSR_MEPC, CSR_MEPC, P_NONE, 1'b1);
    push_row("fence_i", REDIR_FENCE_I, F_FENCE, W_GPR, 5'd13, CSR_MTVEC, CSR_MTVEC, P_BOTH, 1'b0);
    push_row("squash_fence", REDIR_NONE, F_NONE, W_BOTH, 5'd14, CSR_MTVEC, CSR_MTVEC, P_NONE, 1'b1);
    push_row("mispredict", REDIR_MISPREDICT, F_MISP, W_GPR, 5'd15, CSR_MTVEC, CSR_MTVEC,
             P_FLUSH, 1'b0);
    push_row("squash_misp", REDIR_NONE, F_NONE, W_GPR, 5'd1, CSR_MEPC, CSR_MEPC, P_NONE, 1'b1);
    push_row("plain_last", REDIR_NONE, F_NONE, W_BOTH, 5'd2, CSR_MTVEC, CSR_MTVEC, P_NONE, 1'b0);

    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check("reset npc", 32'd0, npc);
    check("reset retire", 32'd0, {29'd0, npc_valid, clear_pipeline, clear_cache});
    check_state("reset");

    idx = 0;
    while (idx < rows.size()) begin
      if (idx + 1 < rows.size() && rows[idx + 1].squash) begin
        apply_row(rows[idx], 1'b1, rows[idx + 1]);
        idx += 2;
      end else begin
        apply_row(rows[idx], 1'b0, rows[idx]);
        idx += 1;
      end
    end
    check_state("final");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+design
design/rv_csr_pkg.sv
design/commit_pkg.sv
design/csr_if.sv
design/gpr_file.sv
design/csr_file.sv
design/trap_unit.sv
design/commit_top.sv
tests/commit_tb.sv

/* Makefile */
# Verilator build and run for the commit block testbench.

VERILATOR ?= verilator
TOP       ?= commit_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= build
OBJ_DIR   ?= $(BUILD_DIR)/obj
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Overridable: VERILATOR TOP FILELIST BUILD_DIR OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	@mkdir -p $(BUILD_DIR)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "test passed"; \
	else \
	  echo "test failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
